/* project.f */
src/pll_track_pkg.sv
src/master_sampler.sv
src/sample_sync.sv
src/phase_detector.sv
src/moving_average.sv
src/shift_request.sv
src/pll_track_top.sv
tb/pll_track_properties.sv
tb/tb_pll_track.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pll_track -f project.f -o sim_pll_track
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pll_track > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0

/* src/master_sampler.sv */
`timescale 1ns/10ps

module master_sampler import pll_track_pkg::*; (
    input  logic    clk_156_25_master,
    input  logic    ACCUM_reset,
    input  period_t sample_period,
    output count_t  master_sample
);

    // Reset brought into the master domain
    logic rst_meta;
    logic rst_sync;

    count_t  master_count;
    period_t sampler_cnt;
    period_t hold_end;

    // Last count of one sample interval
    assign hold_end = sample_period + period_t'(SAMPLE_HOLD);

    // Two-flop synchronizer, no reset of its own
    always_ff @(posedge clk_156_25_master) begin
        rst_meta <= ACCUM_reset;
        rst_sync <= rst_meta;
    end

    // Free-running master cycle counter
    always_ff @(posedge clk_156_25_master) begin
        if (rst_sync) begin
            master_count <= '0;
        end else begin
            master_count <= master_count + count_t'(1);
        end
    end

    // Capture once per sample_period + SAMPLE_HOLD + 1 cycles
    // Capture register moves on a single edge, then holds for the slave side
    always_ff @(posedge clk_156_25_master) begin
        if (rst_sync) begin
            sampler_cnt   <= '0;
            master_sample <= '0;
        end else if (sampler_cnt >= hold_end) begin
            sampler_cnt <= '0;
        end else begin
            if (sampler_cnt == sample_period) begin
                master_sample <= master_count;
            end
            sampler_cnt <= sampler_cnt + period_t'(1);
        end
    end

endmodule

/* src/moving_average.sv */
`timescale 1ns/10ps

module moving_average import pll_track_pkg::*; #(
    parameter int TAPS = FILTER_TAPS
) (
    input  logic   clk_156_25_PS,
    input  logic   ACCUM_reset,
    input  logic   calc_en,
    input  count_t sample_in,
    output count_t average
);

    // Headroom so the sum of TAPS values cannot overflow
    localparam int SUM_W = CNT_W + $clog2(TAPS) + 1;

    count_t                  window [TAPS];
    logic signed [SUM_W-1:0] win_sum;
    logic signed [SUM_W-1:0] quotient;

    // New sample enters at index 0
    always_ff @(posedge clk_156_25_PS) begin
        if (ACCUM_reset) begin
            for (int i = 0; i < TAPS; i++) begin
                window[i] <= '0;
            end
        end else if (calc_en) begin
            window[0] <= sample_in;
            for (int i = 1; i < TAPS; i++) begin
                window[i] <= window[i-1];
            end
        end
    end

    // Signed divide truncates toward zero
    always_comb begin
        win_sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            win_sum = win_sum + SUM_W'(window[i]);
        end
        quotient = win_sum / SUM_W'(TAPS);
    end

    assign average = count_t'(quotient);

endmodule

/* src/phase_detector.sv */
`timescale 1ns/10ps

module phase_detector import pll_track_pkg::*; (
    input  logic   clk_156_25_PS,
    input  logic   ACCUM_reset,
    input  count_t phase_error,
    input  logic   calc_en,
    output count_t accum
);

    localparam int START_W = $clog2(WARMUP_CALCS + 1);

    // Two latest errors, err_new is the most recent
    count_t err_new;
    count_t err_old;

    // Difference pipeline
    count_t diff;
    count_t diff_d;

    logic [START_W-1:0] start_cnt;
    logic               warm;

    // Skip the first calculations while the history fills
    assign warm = (start_cnt > START_W'(WARMUP_MIN));

    always_ff @(posedge clk_156_25_PS) begin
        if (ACCUM_reset) begin
            err_new   <= '0;
            err_old   <= '0;
            diff      <= '0;
            diff_d    <= '0;
            start_cnt <= '0;
            accum     <= '0;
        end else if (calc_en) begin
            err_new <= phase_error;
            err_old <= err_new;
            // Older minus newer, negative when the slave runs ahead
            diff    <= err_old - err_new;
            diff_d  <= diff;
            // Saturating start counter
            if (start_cnt < START_W'(WARMUP_CALCS)) begin
                start_cnt <= start_cnt + 1'b1;
            end
            // Sign of the delayed difference steps the accumulator
            if (warm) begin
                if (diff_d > count_t'(0)) begin
                    accum <= accum + count_t'(1);
                end else if (diff_d < count_t'(0)) begin
                    accum <= accum - count_t'(1);
                end
            end
        end
    end

endmodule

/* src/pll_track_pkg.sv */
package pll_track_pkg;

    // Width of cycle counters, phase error and loop values
    localparam int CNT_W = 32;

    // Signed counts: master/slave counts, phase error, accumulator, filter output
    typedef logic signed [CNT_W-1:0] count_t;

    // Unsigned periods: sample, calculation and step periods
    typedef logic [CNT_W-1:0] period_t;

    // Depth of the master sample history in the slave domain
    localparam int SYNC_DEPTH = 4;

    // Extra master cycles after each capture before the sampler wraps
    localparam int unsigned SAMPLE_HOLD = 4;

    // Calculation start counter saturates here
    localparam int WARMUP_CALCS = 10;
    // Accumulation only once the start counter is above this
    localparam int WARMUP_MIN = 5;

    // Moving-average length of the loop filter
    localparam int FILTER_TAPS = 3;

    // Step period clamp and value after reset
    localparam int STEP_MAX = 8192;
    localparam int STEP_RESET = 512;

    // Shift request FSM
    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_COUNT,
        REQ_WAIT_DONE
    } req_state_t;

endpackage

/* src/pll_track_top.sv */
`timescale 1ns/10ps

module pll_track_top import pll_track_pkg::*; (
    input  logic    clk_156_25_PS,
    input  logic    clk_156_25_master,
    input  logic    ACCUM_reset,
    input  period_t sample_period,
    input  period_t calc_period,
    input  logic    shift_enable,
    input  logic    psdone,
    output logic    psen,
    output logic    psincdec,
    output count_t  phase_error,
    output period_t step_period
);

    // Master domain sample
    count_t master_sample;

    // Slave domain loop values
    logic   calc_en;
    count_t accum;
    count_t filtered;

    master_sampler u_master_sampler (
        .clk_156_25_master (clk_156_25_master),
        .ACCUM_reset       (ACCUM_reset),
        .sample_period     (sample_period),
        .master_sample     (master_sample)
    );

    sample_sync u_sample_sync (
        .clk_156_25_PS (clk_156_25_PS),
        .ACCUM_reset   (ACCUM_reset),
        .master_sample (master_sample),
        .calc_period   (calc_period),
        .phase_error   (phase_error),
        .calc_en       (calc_en)
    );

    phase_detector u_phase_detector (
        .clk_156_25_PS (clk_156_25_PS),
        .ACCUM_reset   (ACCUM_reset),
        .phase_error   (phase_error),
        .calc_en       (calc_en),
        .accum         (accum)
    );

    // Loop filter
    moving_average #(
        .TAPS (FILTER_TAPS)
    ) u_moving_average (
        .clk_156_25_PS (clk_156_25_PS),
        .ACCUM_reset   (ACCUM_reset),
        .calc_en       (calc_en),
        .sample_in     (accum),
        .average       (filtered)
    );

    shift_request u_shift_request (
        .clk_156_25_PS (clk_156_25_PS),
        .ACCUM_reset   (ACCUM_reset),
        .filtered      (filtered),
        .shift_enable  (shift_enable),
        .psdone        (psdone),
        .step_period   (step_period),
        .psen          (psen),
        .psincdec      (psincdec)
    );

endmodule

/* src/sample_sync.sv */
`timescale 1ns/10ps

module sample_sync import pll_track_pkg::*; (
    input  logic    clk_156_25_PS,
    input  logic    ACCUM_reset,
    input  count_t  master_sample,
    input  period_t calc_period,
    output count_t  phase_error,
    output logic    calc_en
);

    // Index 0 is the newest copy of the master sample
    count_t  sync_hist [SYNC_DEPTH];
    count_t  sample_y;
    count_t  slave_count;
    period_t calc_cnt;

    logic sample_stable;
    logic sample_new;
    logic accept_d;
    logic calc_req;
    logic calc_d0;
    logic calc_d1;

    // Newest entries agree, oldest still holds the previous sample
    // Bus may be caught mid-change, so a lone mismatch never passes
    always_comb begin
        sample_stable = 1'b1;
        for (int i = 1; i < SYNC_DEPTH - 1; i++) begin
            sample_stable = sample_stable & (sync_hist[i] == sync_hist[0]);
        end
        sample_new = sample_stable && (sync_hist[SYNC_DEPTH-1] != sync_hist[0]);
    end

    always_ff @(posedge clk_156_25_PS) begin
        if (ACCUM_reset) begin
            for (int i = 0; i < SYNC_DEPTH; i++) begin
                sync_hist[i] <= '0;
            end
            sample_y    <= '0;
            slave_count <= '0;
            phase_error <= '0;
            accept_d    <= 1'b0;
            calc_cnt    <= '0;
            calc_req    <= 1'b0;
            calc_d0     <= 1'b0;
            calc_d1     <= 1'b0;
            calc_en     <= 1'b0;
        end else begin
            // Crossing history
            sync_hist[0] <= master_sample;
            for (int i = 1; i < SYNC_DEPTH; i++) begin
                sync_hist[i] <= sync_hist[i-1];
            end
            slave_count <= slave_count + count_t'(1);
            accept_d    <= sample_new;
            calc_req    <= 1'b0;
            if (sample_new) begin
                sample_y <= sync_hist[0];
                // One calculation per calc_period + 1 accepted samples
                if (calc_cnt >= calc_period) begin
                    calc_cnt <= '0;
                    calc_req <= 1'b1;
                end else begin
                    calc_cnt <= calc_cnt + period_t'(1);
                end
            end
            // Error only refreshed once per accepted sample
            if (accept_d) begin
                phase_error <= slave_count - sample_y;
            end
            // Delay so calc_en sees the refreshed error, rising edge only
            calc_d0 <= calc_req;
            calc_d1 <= calc_d0;
            calc_en <= calc_d0 & ~calc_d1;
        end
    end

endmodule

/* src/shift_request.sv */
`timescale 1ns/10ps

module shift_request import pll_track_pkg::*; (
    input  logic    clk_156_25_PS,
    input  logic    ACCUM_reset,
    input  count_t  filtered,
    input  logic    shift_enable,
    input  logic    psdone,
    output period_t step_period,
    output logic    psen,
    output logic    psincdec
);

    req_state_t state;
    period_t    interval_cnt;

    // Clamp into 0..STEP_MAX, direction from the unclamped sign
    always_ff @(posedge clk_156_25_PS) begin
        if (ACCUM_reset) begin
            step_period <= period_t'(STEP_RESET);
            psincdec    <= 1'b1;
        end else begin
            if (filtered > count_t'(STEP_MAX)) begin
                step_period <= period_t'(STEP_MAX);
            end else if (filtered < count_t'(0)) begin
                step_period <= '0;
            end else begin
                step_period <= period_t'(filtered);
            end
            psincdec <= ~filtered[CNT_W-1];
        end
    end

    // Request FSM, psen is a single-cycle pulse
    always_ff @(posedge clk_156_25_PS) begin
        if (ACCUM_reset) begin
            state        <= REQ_IDLE;
            interval_cnt <= '0;
            psen         <= 1'b0;
        end else begin
            psen <= 1'b0;
            case (state)
                REQ_IDLE: begin
                    interval_cnt <= '0;
                    state        <= REQ_COUNT;
                end
                REQ_COUNT: begin
                    if (interval_cnt >= step_period) begin
                        interval_cnt <= '0;
                        // Disabled means start the interval again
                        if (shift_enable) begin
                            psen  <= 1'b1;
                            state <= REQ_WAIT_DONE;
                        end
                    end else begin
                        interval_cnt <= interval_cnt + period_t'(1);
                    end
                end
                REQ_WAIT_DONE: begin
                    // Hold here however late psdone is
                    if (psdone) begin
                        interval_cnt <= '0;
                        state        <= REQ_COUNT;
                    end
                end
                default: begin
                    state <= REQ_IDLE;
                end
            endcase
        end
    end

endmodule

/* tb/pll_track_properties.sv */
`timescale 1ns/10ps

module pll_track_properties import pll_track_pkg::*; (
    input logic    clk_156_25_PS,
    input logic    ACCUM_reset,
    input logic    psen,
    input logic    psdone,
    input logic    psincdec,
    input period_t step_period
);

    // High from a psen until its psdone
    logic waiting;

    always_ff @(posedge clk_156_25_PS) begin
        if (ACCUM_reset) begin
            waiting <= 1'b0;
        end else if (psen) begin
            waiting <= 1'b1;
        end else if (psdone) begin
            waiting <= 1'b0;
        end
    end

    // Single-cycle psen
    a_psen_pulse: assert property (@(posedge clk_156_25_PS) disable iff (ACCUM_reset)
        psen |=> !psen)
        else $error("psen stayed high for more than one cycle");

    // No new request before psdone
    a_wait_done: assert property (@(posedge clk_156_25_PS) disable iff (ACCUM_reset)
        waiting |-> !psen)
        else $error("psen issued again before psdone");

    a_reset_values: assert property (@(posedge clk_156_25_PS)
        ACCUM_reset |=> (!psen && psincdec && step_period == period_t'(STEP_RESET)))
        else $error("Outputs not at their reset values during reset");

endmodule

bind shift_request pll_track_properties u_properties (
    .clk_156_25_PS (clk_156_25_PS),
    .ACCUM_reset   (ACCUM_reset),
    .psen          (psen),
    .psdone        (psdone),
    .psincdec      (psincdec),
    .step_period   (step_period)
);

/* tb/pll_track_vectors.txt */
# sample_period calc_period shift_enable slave_offset_10ps run_cycles
# exp_step_period exp_psincdec exp_no_psen err_mode(0 none, 1 constant, 2 growing)
20 1 1 0 3000 0 1 0 1
20 1 1 100 3000 0 0 0 2
20 1 0 100 2500 0 0 1 2
10 0 0 0 1500 0 1 1 1

/* tb/tb_pll_track.sv */
`timescale 1ns/10ps

module tb_pll_track;
    import pll_track_pkg::*;

    localparam int MAX_TESTS = 16;
    localparam int RESET_CYCLES = 10;

    logic    clk_156_25_PS;
    logic    clk_156_25_master;
    logic    ACCUM_reset;
    period_t sample_period;
    period_t calc_period;
    logic    shift_enable;
    logic    psdone;
    logic    psen;
    logic    psincdec;
    count_t  phase_error;
    period_t step_period;

    // One row per test from the vector file
    int      num_tests;
    period_t vec_sample [MAX_TESTS];
    period_t vec_calc [MAX_TESTS];
    logic    vec_shift [MAX_TESTS];
    int      vec_offset [MAX_TESTS];
    int      vec_run [MAX_TESTS];
    period_t vec_step [MAX_TESTS];
    logic    vec_incdec [MAX_TESTS];
    logic    vec_no_psen [MAX_TESTS];
    int      vec_err_mode [MAX_TESTS];

    real slave_half;
    bit  vectors_loaded;
    bit  active;
    int  errors;
    int  failed_tests;

    // Monitor counters, cleared per test
    count_t  psen_count;
    count_t  short_gaps;
    count_t  err_changes;
    count_t  first_err;
    count_t  last_err;
    bit      err_seen;
    bit      gap_run;
    period_t gap_cnt;
    period_t gap_min;

    pll_track_top DUT (
        .clk_156_25_PS     (clk_156_25_PS),
        .clk_156_25_master (clk_156_25_master),
        .ACCUM_reset       (ACCUM_reset),
        .sample_period     (sample_period),
        .calc_period       (calc_period),
        .shift_enable      (shift_enable),
        .psdone            (psdone),
        .psen              (psen),
        .psincdec          (psincdec),
        .phase_error       (phase_error),
        .step_period       (step_period)
    );

    // Master clock, phase shifted so edges never coincide with the slave
    initial begin
        clk_156_25_master = 1'b0;
        #7;
        forever #10 clk_156_25_master = ~clk_156_25_master;
    end

    // Slave clock, half period set per test
    initial begin
        clk_156_25_PS = 1'b0;
        slave_half = 10.0;
        forever #(slave_half) clk_156_25_PS = ~clk_156_25_PS;
    end

    task automatic check_count(input string what, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_period(input string what, input period_t got, input period_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Clock manager model, one psdone pulse per psen
    // A reset during the wait drops the pending answer
    initial begin
        bit dropped;
        psdone = 1'b0;
        forever begin
            @(posedge clk_156_25_PS);
            #1;
            if (psen === 1'b1) begin
                dropped = 1'b0;
                repeat (12) begin
                    @(posedge clk_156_25_PS);
                    if (ACCUM_reset === 1'b1) begin
                        dropped = 1'b1;
                    end
                end
                if (!dropped) begin
                    #2 psdone = 1'b1;
                    @(posedge clk_156_25_PS);
                    #2 psdone = 1'b0;
                end
            end
        end
    end

    // Outputs sampled on the falling edge where they are stable
    always @(negedge clk_156_25_PS) begin
        if (active) begin
            if (psen === 1'b1) begin
                psen_count <= psen_count + count_t'(1);
            end
            // Phase error history
            if (!err_seen && phase_error != count_t'(0)) begin
                err_seen  <= 1'b1;
                first_err <= phase_error;
            end else if (err_seen && phase_error != last_err) begin
                err_changes <= err_changes + count_t'(1);
            end
            last_err <= phase_error;
            // Spacing from psdone to the next psen
            if (psdone === 1'b1) begin
                gap_run <= 1'b1;
                gap_cnt <= '0;
                gap_min <= step_period;
            end else if (gap_run) begin
                gap_cnt <= gap_cnt + period_t'(1);
                if (step_period < gap_min) begin
                    gap_min <= step_period;
                end
                // At least step_period + 1 cycles after the psdone cycle
                if (psen === 1'b1) begin
                    gap_run <= 1'b0;
                    if (gap_cnt < gap_min + period_t'(1)) begin
                        short_gaps <= short_gaps + count_t'(1);
                    end
                end
            end
        end else begin
            // Idle between tests, next test starts from clean counters
            psen_count  <= '0;
            short_gaps  <= '0;
            err_changes <= '0;
            first_err   <= '0;
            last_err    <= '0;
            err_seen    <= 1'b0;
            gap_run     <= 1'b0;
            gap_cnt     <= '0;
            gap_min     <= '0;
        end
    end

    task automatic load_vectors();
        int    fd;
        int    n;
        int    f [9];
        string line;
        fd = $fopen("tb/pll_track_vectors.txt", "r");
        num_tests = 0;
        if (fd == 0) begin
            $display("Could not open the vector file tb/pll_track_vectors.txt");
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n == 9) begin
                vec_sample[num_tests]   = period_t'(f[0]);
                vec_calc[num_tests]     = period_t'(f[1]);
                vec_shift[num_tests]    = f[2][0];
                vec_offset[num_tests]   = f[3];
                vec_run[num_tests]      = f[4];
                vec_step[num_tests]     = period_t'(f[5]);
                vec_incdec[num_tests]   = f[6][0];
                vec_no_psen[num_tests]  = f[7][0];
                vec_err_mode[num_tests] = f[8];
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int t);
        int errors_before;
        errors_before = errors;
        // Random idle time before the settings change
        repeat ($urandom_range(7, 0)) @(posedge clk_156_25_PS);
        #2;
        ACCUM_reset   = 1'b1;
        sample_period = vec_sample[t];
        calc_period   = vec_calc[t];
        shift_enable  = vec_shift[t];
        // Offset in 10 ps steps off the slave period
        slave_half    = (2000.0 - real'(vec_offset[t])) * 0.005;
        repeat (RESET_CYCLES - 1) @(posedge clk_156_25_PS);
        @(negedge clk_156_25_PS);
        // Values while in reset
        check_bit("psen in reset", psen, 1'b0);
        check_bit("psincdec in reset", psincdec, 1'b1);
        check_period("step_period in reset", step_period, period_t'(STEP_RESET));
        check_count("phase_error in reset", phase_error, count_t'(0));
        @(posedge clk_156_25_PS);
        #2 ACCUM_reset = 1'b0;
        active = 1'b1;
        @(negedge clk_156_25_PS);
        // Values just after release
        check_bit("psen after reset", psen, 1'b0);
        check_bit("psincdec after reset", psincdec, 1'b1);
        check_period("step_period after reset", step_period, period_t'(STEP_RESET));
        check_count("phase_error after reset", phase_error, count_t'(0));
        repeat (vec_run[t]) @(negedge clk_156_25_PS);
        active = 1'b0;
        check_period("final step_period", step_period, vec_step[t]);
        check_bit("final psincdec", psincdec, vec_incdec[t]);
        check_count("short psdone to psen gaps", short_gaps, count_t'(0));
        if (vec_no_psen[t]) begin
            check_count("psen pulses while disabled", psen_count, count_t'(0));
        end
        if (vec_err_mode[t] == 1) begin
            check_count("phase_error changes", err_changes, count_t'(0));
        end else if (vec_err_mode[t] == 2) begin
            check_bit("phase_error growing", (last_err > first_err) ? 1'b1 : 1'b0, 1'b1);
        end
        if (errors == errors_before) begin
            $display("Test %0d passed, %0d psen pulses", t, psen_count);
        end else begin
            $display("Test %0d failed with %0d errors", t, errors - errors_before);
            failed_tests++;
        end
    endtask

    // Watchdog sized from the run lengths in the vector file
    initial begin
        real limit_ns;
        wait (vectors_loaded);
        limit_ns = 2000.0;
        for (int t = 0; t < num_tests; t++) begin
            limit_ns += real'(vec_run[t] + RESET_CYCLES + 20) * 20.0;
        end
        #(limit_ns);
        $display("Watchdog expired, the tests did not complete in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        ACCUM_reset   = 1'b1;
        sample_period = '0;
        calc_period   = '0;
        shift_enable  = 1'b0;
        active        = 1'b0;
        errors        = 0;
        failed_tests  = 0;
        void'($urandom(66236));
        load_vectors();
        vectors_loaded = 1'b1;
        if (num_tests == 0) begin
            $display("No tests were read from the vector file");
            errors++;
        end
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, failed: %0d, errors: %0d", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
